// File: yval_filter_pkg.sv
// ==========================================================
// Y matrix value filter: shared widths and record types
// ==========================================================
`default_nettype none

package yval_filter_pkg;

   localparam int IDX_W            = 16;  // row or column index
   localparam int VAL_W            = 48;  // complex value, two halves
   localparam int ENTRIES_PER_WORD = 4;
   localparam int ADDR_W           = 20;  // row store word address
   localparam int DIAG_ROW_W       = 9;   // row number held in a diag tag

   localparam logic [2:0] DIAG_MARK = 3'b111;

   typedef struct packed
   {
      logic [VAL_W/2-1:0] re;
      logic [VAL_W/2-1:0] im;
   } cplx_t;

   // one tag word, decoded either as a diagonal marker or as a column
   typedef union packed
   {
      struct packed
      {
         logic [2:0]            mark;
         logic [3:0]            rsvd;
         logic [DIAG_ROW_W-1:0] row;
      } diag;
      logic [IDX_W-1:0] col;
   } ytag_u;

   typedef struct packed
   {
      ytag_u tag;
      cplx_t val;
   } yentry_t;

   // slot 0 sits in the top bits of the word
   typedef yentry_t [0:ENTRIES_PER_WORD-1] yword_t;

   typedef struct packed
   {
      logic [IDX_W-1:0] row;
      logic [IDX_W-1:0] col;
      cplx_t            delta;
   } change_t;

   typedef struct packed
   {
      logic [IDX_W-1:0] row;   // pass row
      cplx_t            diag;
      cplx_t            offd;
      cplx_t            delta;
      logic             diag_found;
      logic             offd_found;
   } pass_rec_t;

   typedef struct packed
   {
      cplx_t diag;
      cplx_t offd;
      logic  diag_found;
      logic  offd_found;
   } match_t;

endpackage

`default_nettype wire

// File: row_entry_match.sv
// ==========================================================
// row entry match: priority search of a buffered row for
// the diagonal entry and the requested off-diagonal column
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module row_entry_match
   import yval_filter_pkg::*;
#(
   parameter int ROW_WORDS = 2
)
(
   input  yword_t [ROW_WORDS-1:0] row_buf,
   input  logic   [IDX_W-1:0]     pass_row,
   input  logic   [IDX_W-1:0]     pass_col,
   output match_t                 found
);

   // lowest slot wins, so later hits are ignored once a flag is set
   always_comb
   begin
      yentry_t ent;
      logic    is_diag;

      found = '0;
      for (int w = 0; w < ROW_WORDS; w++)
      begin
         for (int e = 0; e < ENTRIES_PER_WORD; e++)
         begin
            ent     = row_buf[w][e];
            is_diag = (ent.tag.diag.mark == DIAG_MARK);

            // diag view: marker plus the low bits of the row
            if (is_diag && !found.diag_found &&
                ent.tag.diag.row == pass_row[DIAG_ROW_W-1:0])
            begin
               found.diag       = ent.val;
               found.diag_found = 1'b1;
            end

            // col view, only for tags outside the marker range
            if (!is_diag && !found.offd_found && ent.tag.col == pass_col)
            begin
               found.offd       = ent.val;
               found.offd_found = 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: ymem_fetch.sv
// ==========================================================
// row fetch: reads the words of one row from the row store
// over four-phase req/ack into a row buffer
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module ymem_fetch
   import yval_filter_pkg::*;
#(
   parameter int ROW_WORDS = 2
)
(
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   start,
   input  logic   [IDX_W-1:0]     fetch_row,
   input  logic                   mem_ack,
   input  yword_t                 mem_data,
   output logic                   mem_req,
   output logic   [ADDR_W-1:0]    mem_addr,
   output logic                   fetch_done,
   output yword_t [ROW_WORDS-1:0] row_buf
);

   localparam int CNT_W = (ROW_WORDS > 1) ? $clog2(ROW_WORDS) : 1;

   typedef enum logic [1:0]
   {
      F_IDLE,
      F_REQ,   // req high, waiting for ack
      F_REL    // req low, waiting for ack to drop
   } fetch_state_t;

   fetch_state_t     state;
   logic [CNT_W-1:0] word_cnt;
   logic [IDX_W-1:0] row_q;

   // word k of row x sits at x * ROW_WORDS + k
   assign mem_addr = ADDR_W'(row_q) * ADDR_W'(ROW_WORDS) + ADDR_W'(word_cnt);

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         state      <= F_IDLE;
         word_cnt   <= '0;
         mem_req    <= 1'b0;
         fetch_done <= 1'b0;
      end
      else
      begin
         fetch_done <= 1'b0;
         case (state)
            F_IDLE:
            begin
               if (start)
               begin
                  word_cnt <= '0;
                  mem_req  <= 1'b1;
                  state    <= F_REQ;
               end
            end
            F_REQ:
            begin
               if (mem_ack)
               begin
                  mem_req <= 1'b0;
                  state   <= F_REL;
               end
            end
            F_REL:
            begin
               if (!mem_ack)
               begin
                  if (word_cnt == CNT_W'(ROW_WORDS - 1))
                  begin
                     fetch_done <= 1'b1;   // last word in
                     state      <= F_IDLE;
                  end
                  else
                  begin
                     word_cnt <= word_cnt + 1'b1;
                     mem_req  <= 1'b1;
                     state    <= F_REQ;
                  end
               end
            end
            default: state <= F_IDLE;
         endcase
      end
   end

   // row number and captured words
   always_ff @(posedge clock)
   begin
      if (state == F_IDLE && start)
         row_q <= fetch_row;
      if (state == F_REQ && mem_ack)
         row_buf[word_cnt] <= mem_data;   // data valid while ack high
   end

endmodule

`default_nettype wire

// File: change_sequencer.sv
// ==========================================================
// change sequencer: two fetch/match passes per change and
// the change and output req/ack handshakes
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module change_sequencer
   import yval_filter_pkg::*;
(
   input  logic             clock,
   input  logic             reset,
   input  logic             chg_req,
   input  change_t          chg,
   input  logic             fetch_done,
   input  match_t           found,
   input  logic             out_ack,
   output logic             chg_ack,
   output logic             start,
   output logic [IDX_W-1:0] fetch_row,
   output logic [IDX_W-1:0] pass_col,
   output logic             out_req,
   output pass_rec_t        rec
);

   typedef enum logic [2:0]
   {
      S_IDLE,
      S_FETCH,     // waiting for the row to be read
      S_OUT_REQ,   // out_req high until out_ack
      S_OUT_REL,   // out_req low until out_ack drops
      S_CHG_ACK    // chg_ack high until chg_req drops
   } seq_state_t;

   seq_state_t state;
   change_t    chg_q;
   logic       pass;   // 0: row r col c, 1: row c col r

   // pass 1 swaps row and column
   assign fetch_row = pass ? chg_q.col : chg_q.row;
   assign pass_col  = pass ? chg_q.row : chg_q.col;

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         state   <= S_IDLE;
         pass    <= 1'b0;
         start   <= 1'b0;
         out_req <= 1'b0;
         chg_ack <= 1'b0;
      end
      else
      begin
         start <= 1'b0;
         case (state)
            S_IDLE:
            begin
               if (chg_req)
               begin
                  pass  <= 1'b0;
                  start <= 1'b1;
                  state <= S_FETCH;
               end
            end
            S_FETCH:
            begin
               if (fetch_done)
               begin
                  out_req <= 1'b1;
                  state   <= S_OUT_REQ;
               end
            end
            S_OUT_REQ:
            begin
               if (out_ack)
               begin
                  out_req <= 1'b0;
                  state   <= S_OUT_REL;
               end
            end
            S_OUT_REL:
            begin
               if (!out_ack)
               begin
                  if (!pass)
                  begin
                     pass  <= 1'b1;   // second pass, swapped indices
                     start <= 1'b1;
                     state <= S_FETCH;
                  end
                  else
                  begin
                     chg_ack <= 1'b1;
                     state   <= S_CHG_ACK;
                  end
               end
            end
            S_CHG_ACK:
            begin
               if (!chg_req)
               begin
                  chg_ack <= 1'b0;
                  state   <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // change latch and output record
   always_ff @(posedge clock)
   begin
      if (state == S_IDLE && chg_req)
         chg_q <= chg;
      if (state == S_FETCH && fetch_done)
      begin
         rec.row        <= fetch_row;
         rec.diag       <= found.diag;
         rec.offd       <= found.offd;
         rec.delta      <= chg_q.delta;
         rec.diag_found <= found.diag_found;
         rec.offd_found <= found.offd_found;
      end
   end

endmodule

`default_nettype wire

// File: yval_filter.sv
// ==========================================================
// Y value filter top: fetches the rows touched by a change
// and emits one record per pass
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module yval_filter
   import yval_filter_pkg::*;
#(
   parameter int ROW_WORDS = 2   // words per matrix row, 1 to 8
)
(
   input  logic              clock,
   input  logic              reset,
   input  logic              chg_req,
   input  change_t           chg,
   output logic              chg_ack,
   output logic              mem_req,
   output logic [ADDR_W-1:0] mem_addr,
   input  logic              mem_ack,
   input  yword_t            mem_data,
   output logic              out_req,
   output pass_rec_t         rec,
   input  logic              out_ack
);

   logic                   start;
   logic                   fetch_done;
   logic [IDX_W-1:0]       fetch_row;
   logic [IDX_W-1:0]       pass_col;
   match_t                 found;
   yword_t [ROW_WORDS-1:0] row_buf;

   change_sequencer u_seq
   (
      .clock      (clock),
      .reset      (reset),
      .chg_req    (chg_req),
      .chg        (chg),
      .fetch_done (fetch_done),
      .found      (found),
      .out_ack    (out_ack),
      .chg_ack    (chg_ack),
      .start      (start),
      .fetch_row  (fetch_row),
      .pass_col   (pass_col),
      .out_req    (out_req),
      .rec        (rec)
   );

   ymem_fetch #(.ROW_WORDS(ROW_WORDS)) u_fetch
   (
      .clock      (clock),
      .reset      (reset),
      .start      (start),
      .fetch_row  (fetch_row),
      .mem_ack    (mem_ack),
      .mem_data   (mem_data),
      .mem_req    (mem_req),
      .mem_addr   (mem_addr),
      .fetch_done (fetch_done),
      .row_buf    (row_buf)
   );

   row_entry_match #(.ROW_WORDS(ROW_WORDS)) u_match
   (
      .row_buf  (row_buf),
      .pass_row (fetch_row),
      .pass_col (pass_col),
      .found    (found)
   );

endmodule

`default_nettype wire

// File: tb_row_store.sv
// ==========================================================
// behavioral row store answering req/ack with random delays
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module tb_row_store
   import yval_filter_pkg::*;
#(
   parameter int DEPTH = 256
)
(
   input  logic              clock,
   input  logic              reset,
   input  logic              mem_req,
   input  logic [ADDR_W-1:0] mem_addr,
   output logic              mem_ack,
   output yword_t            mem_data
);

   localparam int AW = $clog2(DEPTH);

   yword_t words [DEPTH];   // row image, loaded by the testbench

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // one word per four-phase cycle, ack comes 0 to 5 cycles after req
   initial
   begin
      logic [31:0] rng;
      int          wait_left;
      logic        busy;
      rng       = 32'h04c2_56cd;
      wait_left = 0;
      busy      = 1'b0;
      mem_ack   = 1'b0;
      mem_data  = '0;
      forever
      begin
         @(negedge clock);
         if (!reset)
         begin
            mem_ack = 1'b0;
            busy    = 1'b0;
         end
         else if (mem_ack)
         begin
            if (!mem_req)
               mem_ack = 1'b0;   // release phase
         end
         else if (mem_req)
         begin
            if (!busy)
            begin
               rng       = xorshift32(rng);
               wait_left = int'(rng % 32'd6);
               busy      = 1'b1;
            end
            if (wait_left == 0)
            begin
               mem_data = words[AW'(mem_addr)];
               mem_ack  = 1'b1;
               busy     = 1'b0;
            end
            else
               wait_left--;
         end
      end
   end

endmodule

`default_nettype wire

// File: yval_filter_props.sv
// ==========================================================
// handshake checks bound to the filter top level
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module yval_filter_props
   import yval_filter_pkg::*;
(
   input logic              clock,
   input logic              reset,
   input logic              out_req,
   input logic              out_ack,
   input pass_rec_t         rec,
   input logic              mem_req,
   input logic              mem_ack,
   input logic [ADDR_W-1:0] mem_addr,
   input logic              chg_ack
);

   // output record held until taken
   assert property (@(posedge clock) disable iff (!reset)
                    out_req && !out_ack |=> out_req && $stable(rec))
      else $error("out_req dropped or rec changed before out_ack");

   // row store request held until answered
   assert property (@(posedge clock) disable iff (!reset)
                    mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
      else $error("mem_req dropped or mem_addr changed before mem_ack");

   assert property (@(posedge clock) disable iff (!reset)
                    $rose(chg_ack) |-> !out_req)
      else $error("chg_ack rose while an output record was pending");

endmodule

`default_nettype wire

// File: yval_filter_tb.sv
// ==========================================================
// Y value filter testbench with change table and reference search
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module yval_filter_tb
   import yval_filter_pkg::*;
();

   localparam int ROW_WORDS = 2;
   localparam int SLOTS     = ROW_WORDS * ENTRIES_PER_WORD;
   localparam int DEPTH     = 256;
   localparam int AW        = $clog2(DEPTH);
   localparam int SW        = $clog2(ENTRIES_PER_WORD);
   localparam int TIMEOUT   = 200;   // cycles per wait

   typedef struct packed
   {
      logic [3:0]       test;   // owning change
      logic [IDX_W-1:0] row;
      logic [2:0]       slot;   // 0 to 7 over both words
      logic [IDX_W-1:0] tag;
   } place_t;

   logic              clock;
   logic              reset;
   logic              chg_req;
   change_t           chg;
   logic              chg_ack;
   logic              mem_req;
   logic [ADDR_W-1:0] mem_addr;
   logic              mem_ack;
   yword_t            mem_data;
   logic              out_req;
   pass_rec_t         rec;
   logic              out_ack;
   logic [31:0]       rng_state;
   logic [ADDR_W-1:0] next_addr;   // next word the row fetch should ask for
   logic              req_seen;
   change_t           changes[$];
   string             names[$];
   place_t            places[$];

   yval_filter #(.ROW_WORDS(ROW_WORDS)) DUT
   (
      .clock(clock), .reset(reset), .chg_req(chg_req), .chg(chg), .chg_ack(chg_ack),
      .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_data(mem_data),
      .out_req(out_req), .rec(rec), .out_ack(out_ack)
   );

   tb_row_store #(.DEPTH(DEPTH)) store
   (
      .clock(clock), .reset(reset), .mem_req(mem_req), .mem_addr(mem_addr),
      .mem_ack(mem_ack), .mem_data(mem_data)
   );

   bind yval_filter yval_filter_props u_props
   (
      .clock(clock), .reset(reset), .out_req(out_req), .out_ack(out_ack), .rec(rec),
      .mem_req(mem_req), .mem_ack(mem_ack), .mem_addr(mem_addr), .chg_ack(chg_ack)
   );

   always #4 clock = ~clock;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic stop_on_fail();
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic add_change(input string name, input logic [IDX_W-1:0] r,
                             input logic [IDX_W-1:0] c, input logic [23:0] re,
                             input logic [23:0] im);
      names.push_back(name);
      changes.push_back('{r, c, '{re, im}});
   endtask

   task automatic add_place(input int t, input logic [IDX_W-1:0] r, input logic [2:0] s,
                            input logic [IDX_W-1:0] tag);
      places.push_back('{4'(t), r, s, tag});
   endtask

   // background tags sit at 8000 and up and are never a tested column
   task automatic load_image(input int t);
      yentry_t ent;
      place_t  p;
      int      a;
      for (a = 0; a < DEPTH; a++)
      begin
         for (int s = 0; s < ENTRIES_PER_WORD; s++)
         begin
            ent.tag.col = 16'h8000 | 16'(a * ENTRIES_PER_WORD + s);
            ent.val.re  = {4'h3, 12'(a), 8'(s)};
            ent.val.im  = {12'(a), 4'hc, 8'(s)} ^ 24'h5a5a5a;
            store.words[AW'(a)][SW'(s)] = ent;
         end
      end
      for (int i = 0; i < places.size(); i++)
      begin
         p = places[i];
         if (int'(p.test) == t)
         begin
            a           = int'(p.row) * ROW_WORDS + int'(p.slot) / ENTRIES_PER_WORD;
            ent.tag.col = p.tag;
            ent.val.re  = {4'ha, 4'(t), 8'(p.row), 5'd0, p.slot};
            ent.val.im  = {8'(p.row), 5'd0, p.slot, 4'(t), 4'h7};
            store.words[AW'(a)][SW'(int'(p.slot) % ENTRIES_PER_WORD)] = ent;
         end
      end
   endtask

   // walks slots top down so the lowest hit is the one kept
   function automatic pass_rec_t expect_pass(input logic [IDX_W-1:0] prow,
                                             input logic [IDX_W-1:0] pcol, input cplx_t delta);
      pass_rec_t   r;
      yentry_t     ent;
      logic [15:0] tag;
      int          a;
      r       = '0;
      r.row   = prow;
      r.delta = delta;
      for (int k = SLOTS - 1; k >= 0; k--)
      begin
         a   = int'(prow) * ROW_WORDS + k / ENTRIES_PER_WORD;
         ent = store.words[AW'(a)][SW'(k % ENTRIES_PER_WORD)];
         tag = ent.tag;
         if (tag[15:13] == 3'b111)
         begin
            if (tag[8:0] == prow[8:0])
            begin
               r.diag       = ent.val;
               r.diag_found = 1'b1;
            end
         end
         else if (tag == pcol)
         begin
            r.offd       = ent.val;
            r.offd_found = 1'b1;
         end
      end
      return r;
   endfunction

   task automatic check_idle(input int cycles);
      repeat (cycles)
      begin
         @(negedge clock);
         assert (!chg_ack && !mem_req && !out_req) else
         begin
            $display("outputs not idle: chg_ack=%b mem_req=%b out_req=%b",
                     chg_ack, mem_req, out_req);
            stop_on_fail();
         end
      end
   endtask

   // words of a row are requested in order from its first address
   task automatic check_mem_addr(input string what);
      if (mem_req && !req_seen)
      begin
         assert (mem_addr === next_addr) else
         begin
            $display("FAILED %s word address: expected %h, actual %h",
                     what, next_addr, mem_addr);
            stop_on_fail();
         end
         next_addr = next_addr + 1'b1;
      end
      req_seen = mem_req;
   endtask

   // chg_ack must stay low for the whole pass
   task automatic wait_out_req(input logic level, input string what);
      int n;
      n = 0;
      while (out_req !== level && n < TIMEOUT)
      begin
         check_mem_addr(what);
         assert (!chg_ack) else
         begin
            $display("chg_ack high during a pass of %s", what);
            stop_on_fail();
         end
         @(negedge clock);
         n++;
      end
      assert (out_req === level) else
      begin
         $display("timed out waiting for out_req to become %b in %s", level, what);
         stop_on_fail();
      end
   endtask

   task automatic wait_chg_ack(input logic level, input string what);
      int n;
      n = 0;
      while (chg_ack !== level && n < TIMEOUT)
      begin
         assert (!out_req) else
         begin
            $display("extra output record after the second pass of %s", what);
            stop_on_fail();
         end
         @(negedge clock);
         n++;
      end
      assert (chg_ack === level) else
      begin
         $display("timed out waiting for chg_ack to become %b in %s", level, what);
         stop_on_fail();
      end
   endtask

   task automatic run_change(input int t);
      change_t   c;
      pass_rec_t exp;
      c       = changes[t];
      chg     = c;
      chg_req = 1'b1;
      for (int p = 0; p < 2; p++)
      begin
         exp = (p == 0) ? expect_pass(c.row, c.col, c.delta)
                        : expect_pass(c.col, c.row, c.delta);
         // word 0 of the pass row comes first
         next_addr = ADDR_W'(int'((p == 0) ? c.row : c.col) * ROW_WORDS);
         wait_out_req(1'b1, names[t]);
         assert (rec === exp) else
         begin
            $display("FAILED %s pass %0d: expected %h, actual %h", names[t], p, exp, rec);
            stop_on_fail();
         end
         rng_state = xorshift32(rng_state);
         repeat (int'(rng_state % 32'd7)) @(negedge clock);   // slow consumer
         out_ack = 1'b1;
         wait_out_req(1'b0, names[t]);
         out_ack = 1'b0;
      end
      wait_chg_ack(1'b1, names[t]);
      chg_req = 1'b0;
      wait_chg_ack(1'b0, names[t]);
   endtask

   initial
   begin
      clock     = 1'b0;
      reset     = 1'b0;
      chg_req   = 1'b0;
      chg       = '0;
      out_ack   = 1'b0;
      rng_state = 32'h04c2_56cd;
      next_addr = '0;
      req_seen  = 1'b0;

      add_change("both_found", 16'd3, 16'd7, 24'h000123, 24'hfff001);
      add_change("absent", 16'd10, 16'd12, 24'h0a0b0c, 24'h000042);
      add_change("priority_word1", 16'd20, 16'd21, 24'h7fffff, 24'h800000);
      add_change("same_row", 16'd30, 16'd30, 24'h111111, 24'h222222);
      add_change("late_slots", 16'd40, 16'd41, 24'h00abcd, 24'hffff00);

      add_place(0, 16'd3, 3'd1, 16'he003);
      add_place(0, 16'd3, 3'd2, 16'h0007);
      add_place(0, 16'd7, 3'd0, 16'he007);
      add_place(0, 16'd7, 3'd3, 16'h0003);
      add_place(1, 16'd10, 3'd0, 16'he00c);   // diag form of another row
      add_place(1, 16'd10, 3'd1, 16'h000d);
      add_place(1, 16'd12, 3'd5, 16'he00c);
      add_place(1, 16'd12, 3'd2, 16'he00a);
      add_place(2, 16'd20, 3'd6, 16'h0015);
      add_place(2, 16'd20, 3'd2, 16'h0015);   // lower slot wins
      add_place(2, 16'd20, 3'd7, 16'he014);
      add_place(2, 16'd21, 3'd4, 16'h0014);
      add_place(2, 16'd21, 3'd6, 16'h0014);
      add_place(2, 16'd21, 3'd5, 16'he015);
      add_place(2, 16'd21, 3'd7, 16'he015);
      add_place(3, 16'd30, 3'd0, 16'he01e);
      add_place(3, 16'd30, 3'd3, 16'h001e);
      add_place(4, 16'd40, 3'd7, 16'h0029);
      add_place(4, 16'd40, 3'd4, 16'he028);
      add_place(4, 16'd41, 3'd6, 16'he029);
      add_place(4, 16'd41, 3'd5, 16'h0028);

      repeat (3) @(negedge clock);
      reset = 1'b1;
      check_idle(4);
      foreach (changes[t])
      begin
         load_image(t);
         run_change(t);
      end
      check_idle(4);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: yval_filter.f
yval_filter_pkg.sv
row_entry_match.sv
ymem_fetch.sv
change_sequencer.sv
yval_filter.sv
tb_row_store.sv
yval_filter_props.sv
yval_filter_tb.sv

// File: run.sh
#!/bin/sh
# build the filter testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module yval_filter_tb -f yval_filter.f -o yval_filter_sim \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/yval_filter_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
